// File: verilog/periph_pkg.sv
// ----------------------------------------------------------
// Shared sizes, source ids and register maps of the
// peripheral subsystem
// ----------------------------------------------------------
package periph_pkg;

  localparam int DATA_W   = 32;
  localparam int ADDR_W   = 32;
  localparam int OFFSET_W = 6;

  localparam int NUM_GPIO   = 8;
  localparam int NUM_TIMERS = 2;
  localparam int NUM_EXT    = 5;

  // Id 0 means no interrupt
  localparam int NUM_SRC        = 16;
  localparam int SRC_ID_W       = 4;
  localparam int SRC_GPIO_BASE  = 1;
  localparam int SRC_TIMER_BASE = 9;
  localparam int SRC_EXT_BASE   = 11;

  // Taken from address bits 11:8
  typedef enum logic [3:0] {SEL_IRQ = 4'd0, SEL_GPIO = 4'd1, SEL_TIMER = 4'd2} periph_sel_e;

  typedef enum logic [OFFSET_W-1:0] {
    IRQ_ENABLE = 6'd0, IRQ_PENDING = 6'd1, IRQ_CLAIM = 6'd2, IRQ_MSIP = 6'd3
  } irq_reg_e;

  typedef enum logic [OFFSET_W-1:0] {
    GPIO_OUT = 6'd0, GPIO_OE = 6'd1, GPIO_IN = 6'd2, GPIO_INTR_EN = 6'd3
  } gpio_reg_e;

  typedef enum logic [OFFSET_W-1:0] {
    TIMER_CTRL = 6'd0, TIMER_MTIME = 6'd1, TIMER_CMP0 = 6'd2, TIMER_CMP1 = 6'd3
  } timer_reg_e;

endpackage

// File: verilog/periph_bus_bridge.sv
// ----------------------------------------------------------
// Bus bridge: req/gnt/rvalid transfers to register strobes
// ----------------------------------------------------------
`timescale 1ns/1ps

module periph_bus_bridge (
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  logic                                req_i,
  input  logic                                we_i,
  input  logic [periph_pkg::ADDR_W-1:0]       addr_i,
  input  logic [periph_pkg::DATA_W-1:0]       wdata_i,
  input  logic [periph_pkg::DATA_W-1:0]       irq_rdata_i,
  input  logic [periph_pkg::DATA_W-1:0]       gpio_rdata_i,
  input  logic [periph_pkg::DATA_W-1:0]       timer_rdata_i,
  output logic                                gnt_o,
  output logic                                rvalid_o,
  output logic [periph_pkg::DATA_W-1:0]       rdata_o,
  output logic                                err_o,
  output logic                                irq_valid_o,
  output logic                                gpio_valid_o,
  output logic                                timer_valid_o,
  output logic                                reg_write_o,
  output logic [periph_pkg::OFFSET_W-1:0]     reg_offset_o,
  output logic [periph_pkg::DATA_W-1:0]       reg_wdata_o
);

  periph_pkg::periph_sel_e       sel;
  logic                          mapped;
  logic [periph_pkg::DATA_W-1:0] sel_rdata;
  logic                          rvalid_q;
  logic                          err_q;
  logic [periph_pkg::DATA_W-1:0] rdata_q;

  // Response stage always drains, so a request is granted at once
  assign gnt_o = req_i;

  assign sel           = periph_pkg::periph_sel_e'(addr_i[11:8]);
  assign irq_valid_o   = gnt_o && (sel == periph_pkg::SEL_IRQ);
  assign gpio_valid_o  = gnt_o && (sel == periph_pkg::SEL_GPIO);
  assign timer_valid_o = gnt_o && (sel == periph_pkg::SEL_TIMER);
  assign reg_write_o   = we_i;
  assign reg_offset_o  = addr_i[periph_pkg::OFFSET_W+1:2];
  assign reg_wdata_o   = wdata_i;

  always_comb begin
    mapped    = 1'b1;
    sel_rdata = '0;
    case (sel)
      periph_pkg::SEL_IRQ:   sel_rdata = irq_rdata_i;
      periph_pkg::SEL_GPIO:  sel_rdata = gpio_rdata_i;
      periph_pkg::SEL_TIMER: sel_rdata = timer_rdata_i;
      default:               mapped = 1'b0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rvalid_q <= 1'b0;
      err_q    <= 1'b0;
      rdata_q  <= '0;
    end else begin
      rvalid_q <= gnt_o;
      err_q    <= gnt_o && !mapped;
      if (gnt_o) rdata_q <= sel_rdata;
    end
  end

  assign rvalid_o = rvalid_q;
  assign err_o    = err_q;
  assign rdata_o  = rdata_q;

  a_one_strobe: assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0({irq_valid_o, gpio_valid_o, timer_valid_o}));

  a_rvalid_after_gnt: assert property (@(posedge clk_i) disable iff (reset_i)
    rvalid_o |-> $past(gnt_o));

endmodule

// File: verilog/periph_irq_ctrl.sv
// ----------------------------------------------------------
// Interrupt controller with level gateways, enable mask,
// claim/complete and a software interrupt bit
// ----------------------------------------------------------
`timescale 1ns/1ps

module periph_irq_ctrl (
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  logic                                valid_i,
  input  logic                                write_i,
  input  logic [periph_pkg::OFFSET_W-1:0]     offset_i,
  input  logic [periph_pkg::DATA_W-1:0]       wdata_i,
  input  logic [periph_pkg::NUM_SRC-1:0]      src_i,
  output logic [periph_pkg::DATA_W-1:0]       rdata_o,
  output logic                                irq_o,
  output logic                                msip_o
);

  logic [periph_pkg::NUM_SRC-1:0]  enable_q;
  logic [periph_pkg::NUM_SRC-1:0]  pending_q;
  logic [periph_pkg::NUM_SRC-1:0]  pending_d;
  logic [periph_pkg::NUM_SRC-1:0]  in_service_q;
  logic [periph_pkg::NUM_SRC-1:0]  in_service_d;
  logic [periph_pkg::NUM_SRC-1:0]  gw_set;
  logic                            msip_q;
  logic [periph_pkg::SRC_ID_W-1:0] claim_id;
  logic [periph_pkg::SRC_ID_W-1:0] cmp_id;
  logic                            claim_rd;
  logic                            complete_wr;

  assign claim_rd    = valid_i && !write_i && (offset_i == periph_pkg::IRQ_CLAIM);
  assign complete_wr = valid_i && write_i && (offset_i == periph_pkg::IRQ_CLAIM);
  assign cmp_id      = wdata_i[periph_pkg::SRC_ID_W-1:0];

  // Lowest enabled pending id wins
  always_comb begin
    claim_id = '0;
    for (int i = periph_pkg::NUM_SRC - 1; i > 0; i--) begin
      if (pending_q[i] && enable_q[i]) claim_id = i[periph_pkg::SRC_ID_W-1:0];
    end
  end

  // Gateway blocks a source while it is pending or in service
  always_comb begin
    gw_set    = src_i & ~pending_q & ~in_service_q;
    gw_set[0] = 1'b0;
    pending_d    = pending_q | gw_set;
    in_service_d = in_service_q;
    if (claim_rd && claim_id != '0) begin
      pending_d[claim_id]    = 1'b0;
      in_service_d[claim_id] = 1'b1;
    end
    if (complete_wr) in_service_d[cmp_id] = 1'b0;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      enable_q     <= '0;
      pending_q    <= '0;
      in_service_q <= '0;
      msip_q       <= 1'b0;
    end else begin
      pending_q    <= pending_d;
      in_service_q <= in_service_d;
      if (valid_i && write_i) begin
        case (offset_i)
          periph_pkg::IRQ_ENABLE: enable_q <= {wdata_i[periph_pkg::NUM_SRC-1:1], 1'b0};
          periph_pkg::IRQ_MSIP:   msip_q   <= wdata_i[0];
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    rdata_o = '0;
    case (offset_i)
      periph_pkg::IRQ_ENABLE:  rdata_o[periph_pkg::NUM_SRC-1:0]  = enable_q;
      periph_pkg::IRQ_PENDING: rdata_o[periph_pkg::NUM_SRC-1:0]  = pending_q;
      periph_pkg::IRQ_CLAIM:   rdata_o[periph_pkg::SRC_ID_W-1:0] = claim_id;
      periph_pkg::IRQ_MSIP:    rdata_o[0] = msip_q;
      default: ;
    endcase
  end

  assign irq_o  = |(pending_q & enable_q);
  assign msip_o = msip_q;

  a_claim_nonzero: assert property (@(posedge clk_i) disable iff (reset_i)
    irq_o |-> claim_id != '0);

endmodule

// File: verilog/periph_gpio.sv
// ----------------------------------------------------------
// GPIO block with synchronized inputs and level interrupts
// ----------------------------------------------------------
`timescale 1ns/1ps

module periph_gpio (
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  logic                                valid_i,
  input  logic                                write_i,
  input  logic [periph_pkg::OFFSET_W-1:0]     offset_i,
  input  logic [periph_pkg::DATA_W-1:0]       wdata_i,
  input  logic [periph_pkg::NUM_GPIO-1:0]     gpio_i,
  output logic [periph_pkg::DATA_W-1:0]       rdata_o,
  output logic [periph_pkg::NUM_GPIO-1:0]     gpio_o,
  output logic [periph_pkg::NUM_GPIO-1:0]     gpio_oe_o,
  output logic [periph_pkg::NUM_GPIO-1:0]     gpio_intr_o
);

  logic [periph_pkg::NUM_GPIO-1:0] out_q;
  logic [periph_pkg::NUM_GPIO-1:0] oe_q;
  logic [periph_pkg::NUM_GPIO-1:0] intr_en_q;
  logic [periph_pkg::NUM_GPIO-1:0] sync1_q;
  logic [periph_pkg::NUM_GPIO-1:0] sync2_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      out_q     <= '0;
      oe_q      <= '0;
      intr_en_q <= '0;
      sync1_q   <= '0;
      sync2_q   <= '0;
    end else begin
      // Two flop synchronizer on the pins
      sync1_q <= gpio_i;
      sync2_q <= sync1_q;
      if (valid_i && write_i) begin
        case (offset_i)
          periph_pkg::GPIO_OUT:     out_q     <= wdata_i[periph_pkg::NUM_GPIO-1:0];
          periph_pkg::GPIO_OE:      oe_q      <= wdata_i[periph_pkg::NUM_GPIO-1:0];
          periph_pkg::GPIO_INTR_EN: intr_en_q <= wdata_i[periph_pkg::NUM_GPIO-1:0];
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    rdata_o = '0;
    case (offset_i)
      periph_pkg::GPIO_OUT:     rdata_o[periph_pkg::NUM_GPIO-1:0] = out_q;
      periph_pkg::GPIO_OE:      rdata_o[periph_pkg::NUM_GPIO-1:0] = oe_q;
      periph_pkg::GPIO_IN:      rdata_o[periph_pkg::NUM_GPIO-1:0] = sync2_q;
      periph_pkg::GPIO_INTR_EN: rdata_o[periph_pkg::NUM_GPIO-1:0] = intr_en_q;
      default: ;
    endcase
  end

  assign gpio_o      = out_q;
  assign gpio_oe_o   = oe_q;
  assign gpio_intr_o = sync2_q & intr_en_q;

endmodule

// File: verilog/periph_timer.sv
// ----------------------------------------------------------
// Machine timer, 32-bit counter with two compare channels
// ----------------------------------------------------------
`timescale 1ns/1ps

module periph_timer (
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  logic                                valid_i,
  input  logic                                write_i,
  input  logic [periph_pkg::OFFSET_W-1:0]     offset_i,
  input  logic [periph_pkg::DATA_W-1:0]       wdata_i,
  output logic [periph_pkg::DATA_W-1:0]       rdata_o,
  output logic [periph_pkg::NUM_TIMERS-1:0]   timer_irq_o
);

  logic                                                  en_q;
  logic [periph_pkg::DATA_W-1:0]                         mtime_q;
  logic [periph_pkg::NUM_TIMERS-1:0][periph_pkg::DATA_W-1:0] cmp_q;
  logic [periph_pkg::NUM_TIMERS-1:0]                     irq_q;
  logic                                                  wr;
  logic                                                  mtime_wr;

  assign wr       = valid_i && write_i;
  assign mtime_wr = wr && (offset_i == periph_pkg::TIMER_MTIME);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      en_q    <= 1'b0;
      mtime_q <= '0;
      cmp_q   <= '0;
      irq_q   <= '0;
    end else begin
      // A write to mtime wins over the increment
      if (mtime_wr) mtime_q <= wdata_i;
      else if (en_q) mtime_q <= mtime_q + 1'b1;
      if (wr && offset_i == periph_pkg::TIMER_CTRL) en_q <= wdata_i[0];
      if (wr && offset_i == periph_pkg::TIMER_CMP0) cmp_q[0] <= wdata_i;
      if (wr && offset_i == periph_pkg::TIMER_CMP1) cmp_q[1] <= wdata_i;
      for (int k = 0; k < periph_pkg::NUM_TIMERS; k++) begin
        irq_q[k] <= en_q && (mtime_q >= cmp_q[k]);
      end
    end
  end

  always_comb begin
    rdata_o = '0;
    case (offset_i)
      periph_pkg::TIMER_CTRL:  rdata_o[0] = en_q;
      periph_pkg::TIMER_MTIME: rdata_o = mtime_q;
      periph_pkg::TIMER_CMP0:  rdata_o = cmp_q[0];
      periph_pkg::TIMER_CMP1:  rdata_o = cmp_q[1];
      default: ;
    endcase
  end

  assign timer_irq_o = irq_q;

  a_mtime_frozen: assert property (@(posedge clk_i) disable iff (reset_i)
    !en_q && !mtime_wr |=> $stable(mtime_q));

endmodule

// File: verilog/periph_subsystem.sv
// ----------------------------------------------------------
// Peripheral subsystem top: bus bridge, interrupt
// controller, GPIO and machine timer
// ----------------------------------------------------------
`timescale 1ns/1ps

module periph_subsystem (
  input  logic                                clk_i,
  input  logic                                reset_i,
  input  logic                                req_i,
  input  logic                                we_i,
  input  logic [periph_pkg::ADDR_W-1:0]       addr_i,
  input  logic [periph_pkg::DATA_W-1:0]       wdata_i,
  input  logic [periph_pkg::NUM_GPIO-1:0]     gpio_i,
  input  logic [periph_pkg::NUM_EXT-1:0]      intr_ext_i,
  output logic                                gnt_o,
  output logic                                rvalid_o,
  output logic [periph_pkg::DATA_W-1:0]       rdata_o,
  output logic                                err_o,
  output logic [periph_pkg::NUM_GPIO-1:0]     gpio_o,
  output logic [periph_pkg::NUM_GPIO-1:0]     gpio_oe_o,
  output logic                                irq_o,
  output logic                                msip_o,
  output logic [periph_pkg::NUM_TIMERS-1:0]   timer_irq_o
);

  logic                              irq_valid;
  logic                              gpio_valid;
  logic                              timer_valid;
  logic                              reg_write;
  logic [periph_pkg::OFFSET_W-1:0]   reg_offset;
  logic [periph_pkg::DATA_W-1:0]     reg_wdata;
  logic [periph_pkg::DATA_W-1:0]     irq_rdata;
  logic [periph_pkg::DATA_W-1:0]     gpio_rdata;
  logic [periph_pkg::DATA_W-1:0]     timer_rdata;
  logic [periph_pkg::NUM_GPIO-1:0]   gpio_intr;
  logic [periph_pkg::NUM_SRC-1:0]    intr_src;

  // Id 0 is reserved and tied low
  assign intr_src[0] = 1'b0;
  assign intr_src[periph_pkg::SRC_GPIO_BASE +: periph_pkg::NUM_GPIO]    = gpio_intr;
  assign intr_src[periph_pkg::SRC_TIMER_BASE +: periph_pkg::NUM_TIMERS] = timer_irq_o;
  assign intr_src[periph_pkg::SRC_EXT_BASE +: periph_pkg::NUM_EXT]      = intr_ext_i;

  periph_bus_bridge u_bridge (
    .clk_i, .reset_i, .req_i, .we_i, .addr_i, .wdata_i,
    .irq_rdata_i(irq_rdata), .gpio_rdata_i(gpio_rdata), .timer_rdata_i(timer_rdata),
    .gnt_o, .rvalid_o, .rdata_o, .err_o,
    .irq_valid_o(irq_valid), .gpio_valid_o(gpio_valid), .timer_valid_o(timer_valid),
    .reg_write_o(reg_write), .reg_offset_o(reg_offset), .reg_wdata_o(reg_wdata)
  );

  periph_irq_ctrl u_irq_ctrl (
    .clk_i, .reset_i, .valid_i(irq_valid), .write_i(reg_write),
    .offset_i(reg_offset), .wdata_i(reg_wdata), .src_i(intr_src),
    .rdata_o(irq_rdata), .irq_o, .msip_o
  );

  periph_gpio u_gpio (
    .clk_i, .reset_i, .valid_i(gpio_valid), .write_i(reg_write),
    .offset_i(reg_offset), .wdata_i(reg_wdata), .gpio_i,
    .rdata_o(gpio_rdata), .gpio_o, .gpio_oe_o, .gpio_intr_o(gpio_intr)
  );

  periph_timer u_timer (
    .clk_i, .reset_i, .valid_i(timer_valid), .write_i(reg_write),
    .offset_i(reg_offset), .wdata_i(reg_wdata),
    .rdata_o(timer_rdata), .timer_irq_o
  );

endmodule

// File: verif/periph_subsystem_tb.sv
// ----------------------------------------------------------
// Testbench for the peripheral subsystem: directed bus
// tests of GPIO, timer and interrupt controller
// ----------------------------------------------------------
`timescale 1ns/1ps

module periph_subsystem_tb;

  localparam int TIMEOUT_CYCLES = 64;
  localparam logic [periph_pkg::SRC_ID_W-1:0] ID_GPIO2 =
    periph_pkg::SRC_ID_W'(periph_pkg::SRC_GPIO_BASE + 2);
  localparam logic [periph_pkg::SRC_ID_W-1:0] ID_TIMER0 =
    periph_pkg::SRC_ID_W'(periph_pkg::SRC_TIMER_BASE);
  localparam logic [periph_pkg::SRC_ID_W-1:0] ID_EXT0 =
    periph_pkg::SRC_ID_W'(periph_pkg::SRC_EXT_BASE);

  logic                                clk_i;
  logic                                reset_i;
  logic                                req_i;
  logic                                we_i;
  logic [periph_pkg::ADDR_W-1:0]       addr_i;
  logic [periph_pkg::DATA_W-1:0]       wdata_i;
  logic [periph_pkg::NUM_GPIO-1:0]     gpio_i;
  logic [periph_pkg::NUM_EXT-1:0]      intr_ext_i;
  logic                                gnt_o;
  logic                                rvalid_o;
  logic [periph_pkg::DATA_W-1:0]       rdata_o;
  logic                                err_o;
  logic [periph_pkg::NUM_GPIO-1:0]     gpio_o;
  logic [periph_pkg::NUM_GPIO-1:0]     gpio_oe_o;
  logic                                irq_o;
  logic                                msip_o;
  logic [periph_pkg::NUM_TIMERS-1:0]   timer_irq_o;
  logic                                timer0_irq;

  int mismatch_count;
  int timeout_count;

  periph_subsystem u_periph_subsystem (
    .clk_i, .reset_i, .req_i, .we_i, .addr_i, .wdata_i, .gpio_i, .intr_ext_i,
    .gnt_o, .rvalid_o, .rdata_o, .err_o, .gpio_o, .gpio_oe_o, .irq_o, .msip_o,
    .timer_irq_o
  );

  assign timer0_irq = timer_irq_o[0];

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  function automatic logic [periph_pkg::ADDR_W-1:0] reg_addr(
    input logic [3:0] sel, input logic [periph_pkg::OFFSET_W-1:0] off);
    reg_addr = '0;
    reg_addr[11:8] = sel;
    reg_addr[periph_pkg::OFFSET_W+1:2] = off;
  endfunction

  task automatic check_word(input logic [periph_pkg::DATA_W-1:0] got,
                            input logic [periph_pkg::DATA_W-1:0] exp, input string msg);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %h expected %h", $time, msg, got, exp);
      mismatch_count++;
    end
  endtask

  task automatic check_err(input logic got, input logic exp, input string msg);
    if (got !== exp) begin
      $display("mismatch at %0t: %s err got %b expected %b", $time, msg, got, exp);
      mismatch_count++;
    end
  endtask

  task automatic check_id(input logic [periph_pkg::SRC_ID_W-1:0] got,
                          input logic [periph_pkg::SRC_ID_W-1:0] exp, input string msg);
    if (got !== exp) begin
      $display("mismatch at %0t: %s id got %0d expected %0d", $time, msg, got, exp);
      mismatch_count++;
    end
  endtask

  // Drive at the rising edge, sample at the falling edge
  task automatic bus_access(input logic we, input logic [periph_pkg::ADDR_W-1:0] addr,
                            input logic [periph_pkg::DATA_W-1:0] wdata,
                            output logic [periph_pkg::DATA_W-1:0] rdata, output logic err);
    int cycles;
    @(posedge clk_i);
    req_i   <= 1'b1;
    we_i    <= we;
    addr_i  <= addr;
    wdata_i <= wdata;
    cycles = 0;
    @(negedge clk_i);
    while (!gnt_o && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk_i);
      cycles++;
    end
    if (!gnt_o) begin
      $display("timeout at %0t: request to %h was never granted", $time, addr);
      timeout_count++;
    end
    @(posedge clk_i);
    req_i <= 1'b0;
    we_i  <= 1'b0;
    cycles = 0;
    @(negedge clk_i);
    while (!rvalid_o && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk_i);
      cycles++;
    end
    if (!rvalid_o) begin
      $display("timeout at %0t: no response to the request to %h", $time, addr);
      timeout_count++;
    end
    rdata = rdata_o;
    err   = err_o;
  endtask

  task automatic bus_write(input logic [periph_pkg::ADDR_W-1:0] addr,
                           input logic [periph_pkg::DATA_W-1:0] wdata,
                           output logic [periph_pkg::DATA_W-1:0] rdata, output logic err);
    bus_access(1'b1, addr, wdata, rdata, err);
  endtask

  task automatic bus_read(input logic [periph_pkg::ADDR_W-1:0] addr,
                          output logic [periph_pkg::DATA_W-1:0] rdata, output logic err);
    bus_access(1'b0, addr, '0, rdata, err);
  endtask

  // Polls a flag at falling edges until it is high
  task automatic wait_high(ref logic flag, input string what);
    int cycles;
    cycles = 0;
    @(negedge clk_i);
    while (!flag && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk_i);
      cycles++;
    end
    if (!flag) begin
      $display("timeout at %0t: %s never went high", $time, what);
      timeout_count++;
    end
  endtask

  task automatic reset_and_readback();
    logic [periph_pkg::DATA_W-1:0] data;
    logic [periph_pkg::DATA_W-1:0] rdata;
    logic                          err;
    check_word(32'({gnt_o, rvalid_o, err_o, irq_o, msip_o, gpio_oe_o, timer_irq_o}), '0,
               "control outputs after reset");
    data = $urandom;
    bus_write(reg_addr(periph_pkg::SEL_GPIO, periph_pkg::GPIO_OUT), data, rdata, err);
    check_word(32'(gpio_o), data & 32'hff, "gpio_o");
    bus_read(reg_addr(periph_pkg::SEL_GPIO, periph_pkg::GPIO_OUT), rdata, err);
    check_word(rdata, data & 32'hff, "GPIO_OUT readback");
    check_err(err, 1'b0, "GPIO_OUT read");
    data = $urandom;
    bus_write(reg_addr(periph_pkg::SEL_GPIO, periph_pkg::GPIO_OE), data, rdata, err);
    check_word(32'(gpio_oe_o), data & 32'hff, "gpio_oe_o");
    bus_read(reg_addr(periph_pkg::SEL_GPIO, periph_pkg::GPIO_OE), rdata, err);
    check_word(rdata, data & 32'hff, "GPIO_OE readback");
    data = $urandom;
    bus_write(reg_addr(periph_pkg::SEL_TIMER, periph_pkg::TIMER_CMP0), data, rdata, err);
    bus_read(reg_addr(periph_pkg::SEL_TIMER, periph_pkg::TIMER_CMP0), rdata, err);
    check_word(rdata, data, "TIMER_CMP0 readback");
    check_err(err, 1'b0, "TIMER_CMP0 read");
    data = $urandom;
    bus_write(reg_addr(periph_pkg::SEL_TIMER, periph_pkg::TIMER_CMP1), data, rdata, err);
    bus_read(reg_addr(periph_pkg::SEL_TIMER, periph_pkg::TIMER_CMP1), rdata, err);
    check_word(rdata, data, "TIMER_CMP1 readback");
  endtask

  task automatic unmapped_select();
    logic [periph_pkg::DATA_W-1:0] rdata;
    logic                          err;
    bus_write(reg_addr(4'd5, 6'd0), $urandom, rdata, err);
    check_err(err, 1'b1, "unmapped write");
    check_word(rdata, '0, "unmapped write rdata");
    bus_read(reg_addr(4'd5, 6'd1), rdata, err);
    check_err(err, 1'b1, "unmapped read");
    check_word(rdata, '0, "unmapped read rdata");
    bus_read(reg_addr(periph_pkg::SEL_IRQ, periph_pkg::IRQ_ENABLE), rdata, err);
    check_err(err, 1'b0, "mapped read after unmapped");
  endtask

  task automatic gpio_input_sync();
    logic [periph_pkg::DATA_W-1:0] rdata;
    logic                          err;
    logic [periph_pkg::NUM_GPIO-1:0] pins;
    pins = periph_pkg::NUM_GPIO'($urandom);
    @(posedge clk_i);
    gpio_i <= pins;
    // The read below is granted in the second cycle after the pin change
    @(posedge clk_i);
    bus_read(reg_addr(periph_pkg::SEL_GPIO, periph_pkg::GPIO_IN), rdata, err);
    check_word(rdata, 32'(pins), "GPIO_IN after two cycles");
    @(posedge clk_i);
    gpio_i <= '0;
  endtask

  task automatic timer_compare();
    logic [periph_pkg::DATA_W-1:0] rdata;
    logic                          err;
    bus_write(reg_addr(periph_pkg::SEL_TIMER, periph_pkg::TIMER_CTRL), 32'd0, rdata, err);
    bus_write(reg_addr(periph_pkg::SEL_TIMER, periph_pkg::TIMER_MTIME), 32'd0, rdata, err);
    bus_write(reg_addr(periph_pkg::SEL_TIMER, periph_pkg::TIMER_CMP0), 32'd10, rdata, err);
    bus_write(reg_addr(periph_pkg::SEL_TIMER, periph_pkg::TIMER_CMP1), '1, rdata, err);
    bus_write(reg_addr(periph_pkg::SEL_TIMER, periph_pkg::TIMER_CTRL), 32'd1, rdata, err);
    wait_high(timer0_irq, "timer_irq_o[0]");
    check_err(timer_irq_o[1], 1'b0, "timer_irq_o[1] with CMP1 all ones");
    bus_read(reg_addr(periph_pkg::SEL_TIMER, periph_pkg::TIMER_MTIME), rdata, err);
    if (rdata <= 32'd10) begin
      $display("mismatch at %0t: mtime %0d not past compare value 10", $time, rdata);
      mismatch_count++;
    end
    // Stop the timer and retire the latched id of channel 0
    bus_write(reg_addr(periph_pkg::SEL_TIMER, periph_pkg::TIMER_CTRL), 32'd0, rdata, err);
    bus_write(reg_addr(periph_pkg::SEL_IRQ, periph_pkg::IRQ_ENABLE), 32'd1 << ID_TIMER0,
              rdata, err);
    bus_read(reg_addr(periph_pkg::SEL_IRQ, periph_pkg::IRQ_CLAIM), rdata, err);
    check_id(rdata[periph_pkg::SRC_ID_W-1:0], ID_TIMER0, "timer claim");
    bus_write(reg_addr(periph_pkg::SEL_IRQ, periph_pkg::IRQ_CLAIM), 32'(ID_TIMER0), rdata, err);
    bus_write(reg_addr(periph_pkg::SEL_IRQ, periph_pkg::IRQ_ENABLE), 32'd0, rdata, err);
  endtask

  task automatic claim_and_complete();
    logic [periph_pkg::DATA_W-1:0] rdata;
    logic                          err;
    @(posedge clk_i);
    gpio_i     <= 8'h04;
    intr_ext_i <= 5'b00001;
    bus_write(reg_addr(periph_pkg::SEL_GPIO, periph_pkg::GPIO_INTR_EN), 32'h04, rdata, err);
    bus_write(reg_addr(periph_pkg::SEL_IRQ, periph_pkg::IRQ_ENABLE),
              (32'd1 << ID_GPIO2) | (32'd1 << ID_EXT0), rdata, err);
    wait_high(irq_o, "irq_o");
    bus_read(reg_addr(periph_pkg::SEL_IRQ, periph_pkg::IRQ_CLAIM), rdata, err);
    check_id(rdata[periph_pkg::SRC_ID_W-1:0], ID_GPIO2, "first claim");
    bus_read(reg_addr(periph_pkg::SEL_IRQ, periph_pkg::IRQ_CLAIM), rdata, err);
    check_id(rdata[periph_pkg::SRC_ID_W-1:0], ID_EXT0, "second claim");
    bus_read(reg_addr(periph_pkg::SEL_IRQ, periph_pkg::IRQ_PENDING), rdata, err);
    check_word(rdata, '0, "pending with both ids in service");
    repeat (4) begin
      @(negedge clk_i);
      check_err(irq_o, 1'b0, "irq_o before complete");
    end
    bus_write(reg_addr(periph_pkg::SEL_IRQ, periph_pkg::IRQ_CLAIM), 32'(ID_GPIO2), rdata, err);
    bus_read(reg_addr(periph_pkg::SEL_IRQ, periph_pkg::IRQ_PENDING), rdata, err);
    check_word(rdata, 32'd1 << ID_GPIO2, "pending after completing gpio id");
    check_err(irq_o, 1'b1, "irq_o after complete");
  endtask

  task automatic software_irq();
    logic [periph_pkg::DATA_W-1:0] rdata;
    logic                          err;
    bus_write(reg_addr(periph_pkg::SEL_IRQ, periph_pkg::IRQ_MSIP), 32'd1, rdata, err);
    check_err(msip_o, 1'b1, "msip_o after set");
    bus_write(reg_addr(periph_pkg::SEL_IRQ, periph_pkg::IRQ_MSIP), 32'd0, rdata, err);
    check_err(msip_o, 1'b0, "msip_o after clear");
  endtask

  initial begin
    reset_i    = 1'b1;
    req_i      = 1'b0;
    we_i       = 1'b0;
    addr_i     = '0;
    wdata_i    = '0;
    gpio_i     = '0;
    intr_ext_i = '0;
    mismatch_count = 0;
    timeout_count  = 0;
    void'($urandom(32'hd528));
    repeat (2) @(posedge clk_i);
    reset_i <= 1'b0;
    @(negedge clk_i);
    reset_and_readback();
    unmapped_select();
    gpio_input_sync();
    timer_compare();
    claim_and_complete();
    software_irq();
    $display("summary: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
    if (mismatch_count == 0 && timeout_count == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// File: periph_sub.f
verilog/periph_pkg.sv
verilog/periph_bus_bridge.sv
verilog/periph_irq_ctrl.sv
verilog/periph_gpio.sv
verilog/periph_timer.sv
verilog/periph_subsystem.sv
verif/periph_subsystem_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the periph_sub testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module periph_subsystem_tb -f periph_sub.f \
  -o periph_sim > build.log 2>&1 \
  && ./obj_dir/periph_sim > sim.log 2>&1 \
  || { cat build.log sim.log 2>/dev/null; echo "build or run failed"; exit 1; }

cat sim.log
grep -q "ALL CHECKS PASSED" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
